//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module sharedMultiFifoTb \
  -f sharedMultiFifo.f -o simBin \
  && ./obj_dir/simBin +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "=== PASS ===" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- sharedMultiFifo.f
+incdir+verilog
verilog/mfifoPkg.sv
verilog/syncReadRam.sv
verilog/roundRobinArbiter.sv
verilog/freelistPushCtrl.sv
verilog/linkedListPtrMgr.sv
verilog/creditPopCtrl.sv
verilog/sharedMultiFifo.sv
verification/sharedMultiFifo_asserts.sv
verification/sharedMultiFifoTb.sv

//--- verification/sharedMultiFifoTb.sv
`timescale 1ns/1ps

`include "mfifo_defs.svh"

`default_nettype none

module sharedMultiFifoTb
  import mfifoPkg::*;
();

  logic clk;
  logic rstN;
  logic pushValid;
  fifoIdT pushFifoId;
  dataT pushData;
  logic pushCredit;
  logic pushFull;
  logic [`MFIFO_NUM_FIFOS-1:0] popCredit;
  logic popValid;
  fifoIdT popFifoId;
  dataT popData;
  logic [`MFIFO_NUM_FIFOS-1:0] popEmpty;

  // Expected items per FIFO in push order
  dataT scoreboard [`MFIFO_NUM_FIFOS][$];
  // Pop credits the receiver still owes back to the DUT
  int owed [`MFIFO_NUM_FIFOS];
  int popCount [`MFIFO_NUM_FIFOS];
  // Pops of other FIFOs seen while this FIFO had something queued
  int waitCount [`MFIFO_NUM_FIFOS];
  // Push credits the sender holds right now
  int pushCredits;
  int pushCount;
  int creditPulses;
  int errorCount;
  int testCount;
  int testsFailed;
  int assertFails;
  int startErrors;
  int startPops [`MFIFO_NUM_FIFOS];
  int guard;
  // Per FIFO switch that lets the receiver hand credits back
  logic [`MFIFO_NUM_FIFOS-1:0] returnEn;
  bit randomReturn;
  bit fairnessOn;
  logic [31:0] lfsrState;

  sharedMultiFifo sharedMultiFifo_inst (
    .clk, .rstN, .pushValid, .pushFifoId, .pushData, .pushCredit, .pushFull,
    .popCredit, .popValid, .popFifoId, .popData, .popEmpty
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois LFSR that steps once for every bit handed out
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
      val = {val[30:0], lfsrState[0]};
    end
    return val;
  endfunction

  // Items pushed but not yet popped over all FIFOs
  function automatic int queuedItems();
    int total;
    total = 0;
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      total += scoreboard[i].size();
    end
    return total;
  endfunction

  // Nothing queued, every push credit home and no pop credit still owed
  function automatic bit isIdle();
    bit idle;
    idle = (pushCredits == `MFIFO_DEPTH);
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      if (scoreboard[i].size() != 0 || owed[i] != 0) idle = 1'b0;
    end
    return idle;
  endfunction

  // Outputs are read mid-cycle where they have settled
  always @(negedge clk) begin
    if (rstN) begin
      if (popValid) begin
        for (int j = 0; j < `MFIFO_NUM_FIFOS; j++) begin
          if (fifoIdT'(j) == popFifoId) waitCount[j] = 0;
          else if (scoreboard[j].size() > 0) waitCount[j]++;
          else waitCount[j] = 0;
          assert (!fairnessOn || waitCount[j] <= 7) else begin
            $display("FAIL %0t: FIFO %0d waited %0d pops", $time, j, waitCount[j]);
            errorCount++;
          end
        end
        assert (scoreboard[popFifoId].size() > 0) else begin
          $display("FAIL %0t: pop from FIFO %0d with nothing expected", $time, popFifoId);
          errorCount++;
        end
        // Each FIFO must return its items in push order
        if (scoreboard[popFifoId].size() > 0) begin
          assert (popData == scoreboard[popFifoId][0]) else begin
            $display("FAIL %0t: FIFO %0d popped %0h, expected %0h", $time, popFifoId,
                     popData, scoreboard[popFifoId][0]);
            errorCount++;
          end
          void'(scoreboard[popFifoId].pop_front());
        end
        owed[popFifoId]++;
        popCount[popFifoId]++;
      end
      if (pushCredit) begin
        pushCredits++;
        creditPulses++;
      end
      // A push driven in this cycle is not yet in the DUT state
      assert (pushFull == ((pushCredits + int'(pushValid)) == 0)) else begin
        $display("FAIL %0t: pushFull is %0b with %0d credits", $time, pushFull, pushCredits);
        errorCount++;
      end
      for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
        assert (popEmpty[i] ==
                ((scoreboard[i].size() - int'(pushValid && pushFifoId == fifoIdT'(i))) == 0))
        else begin
          $display("FAIL %0t: popEmpty[%0d] is %0b", $time, i, popEmpty[i]);
          errorCount++;
        end
      end
    end
  end

  // One clock of stimulus that pushes only while the sender holds a credit
  task automatic stepCycle(input bit wantPush, input fifoIdT id, input dataT data);
    @(posedge clk);
    #1;
    pushValid = 1'b0;
    if (wantPush && pushCredits > 0) begin
      pushValid = 1'b1;
      pushFifoId = id;
      pushData = data;
      pushCredits--;
      pushCount++;
      scoreboard[id].push_back(data);
    end
    // Credits go back one per cycle per FIFO, optionally at random
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      popCredit[i] = 1'b0;
      if (owed[i] > 0 && returnEn[i] && (!randomReturn || randBits(1) == 32'd1)) begin
        popCredit[i] = 1'b1;
        owed[i]--;
      end
    end
  endtask

  // Pushes a number of items, either round robin over the FIFOs or to random FIFOs
  task automatic pushItems(input int total, input bit spreadEven, input string label);
    int first;
    int cycles;
    first = pushCount;
    cycles = 0;
    while (pushCount - first < total && cycles < 1000) begin
      stepCycle(1'b1, spreadEven ? fifoIdT'((pushCount - first) % `MFIFO_NUM_FIFOS) :
                fifoIdT'(randBits(2)), dataT'(randBits(8)));
      cycles++;
    end
    if (pushCount - first < total) begin
      $display("Timeout: %s pushed only %0d of %0d items", label, pushCount - first, total);
      errorCount++;
    end
  endtask

  // Returns all credits until every queue is empty and all credits are home
  task automatic drainAll(input string label);
    int cycles;
    cycles = 0;
    returnEn = '1;
    randomReturn = 1'b0;
    while (!isIdle() && cycles < 1000) begin
      stepCycle(1'b0, '0, '0);
      cycles++;
    end
    assert (isIdle()) else begin
      $display("Timeout: %s did not drain within 1000 cycles", label);
      errorCount++;
    end
    assert (&popEmpty) else begin
      $display("FAIL %0t: popEmpty %b after %s drained", $time, popEmpty, label);
      errorCount++;
    end
  endtask

  task automatic finishTest(input string name);
    testCount++;
    if (errorCount != startErrors) testsFailed++;
    $display("Test %s: %0d errors", name, errorCount - startErrors);
    startErrors = errorCount;
  endtask

  initial begin
    rstN = 1'b0;
    pushValid = 1'b0;
    pushFifoId = '0;
    pushData = '0;
    popCredit = '0;
    lfsrState = 32'd73443;
    pushCredits = `MFIFO_DEPTH;
    pushCount = 0;
    creditPulses = 0;
    errorCount = 0;
    testCount = 0;
    testsFailed = 0;
    startErrors = 0;
    returnEn = '1;
    randomReturn = 1'b0;
    fairnessOn = 1'b0;
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      owed[i] = 0;
      popCount[i] = 0;
      waitCount[i] = 0;
    end
    repeat (3) @(posedge clk);
    #1;
    rstN = 1'b1;

    @(negedge clk);
    assert (!popValid && !pushCredit && !pushFull && (&popEmpty)) else begin
      $display("FAIL %0t: outputs not idle after reset", $time);
      errorCount++;
    end
    finishTest("reset");

    pushItems(40, 1'b0, "order");
    drainAll("order");
    finishTest("order");

    // Use up the pop credits first so the shared storage can fill
    returnEn = '0;
    pushItems(2 * `MFIFO_NUM_FIFOS, 1'b1, "capacity setup");
    // Those pops must finish and free every entry before the fill starts
    guard = 0;
    while ((pushCredits != `MFIFO_DEPTH || queuedItems() != 0) && guard < 200) begin
      stepCycle(1'b0, '0, '0);
      guard++;
    end
    if (pushCredits != `MFIFO_DEPTH || queuedItems() != 0) begin
      $display("Timeout: capacity setup pops did not finish within 200 cycles");
      errorCount++;
    end
    creditPulses = 0;
    pushItems(`MFIFO_DEPTH, 1'b0, "capacity fill");
    stepCycle(1'b0, '0, '0);
    assert (pushFull) else begin
      $display("FAIL %0t: pushFull low with all entries in use", $time);
      errorCount++;
    end
    drainAll("capacity");
    assert (creditPulses == `MFIFO_DEPTH) else begin
      $display("FAIL %0t: %0d push credits returned", $time, creditPulses);
      errorCount++;
    end
    finishTest("capacity");

    // FIFO 0 never gets a credit back and must stall after its initial ones
    returnEn = 4'b1110;
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) startPops[i] = popCount[i];
    pushItems(20, 1'b1, "back-pressure");
    guard = 0;
    while (scoreboard[1].size() + scoreboard[2].size() + scoreboard[3].size() != 0 &&
           guard < 500) begin
      stepCycle(1'b0, '0, '0);
      guard++;
    end
    if (scoreboard[1].size() + scoreboard[2].size() + scoreboard[3].size() != 0) begin
      $display("Timeout: FIFOs 1 to 3 never emptied while FIFO 0 was stalled");
      errorCount++;
    end
    assert (popCount[0] - startPops[0] == `MFIFO_POP_CREDITS &&
            scoreboard[0].size() == 5 - `MFIFO_POP_CREDITS) else begin
      $display("FAIL %0t: FIFO 0 popped %0d items", $time, popCount[0] - startPops[0]);
      errorCount++;
    end
    drainAll("back-pressure");
    finishTest("back-pressure");

    // Eight items per FIFO with credits returned at once
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      waitCount[i] = 0;
      startPops[i] = popCount[i];
    end
    fairnessOn = 1'b1;
    pushItems(32, 1'b1, "fairness");
    drainAll("fairness");
    fairnessOn = 1'b0;
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      assert (popCount[i] - startPops[i] == 8) else begin
        $display("FAIL %0t: FIFO %0d popped %0d of 8", $time, i, popCount[i] - startPops[i]);
        errorCount++;
      end
    end
    finishTest("fairness");

    // Random pushes and random credit return
    randomReturn = 1'b1;
    for (int c = 0; c < 400; c++) begin
      stepCycle(randBits(1) == 32'd1, fifoIdT'(randBits(2)), dataT'(randBits(8)));
    end
    drainAll("random");
    assert (pushCredits == `MFIFO_DEPTH) else begin
      $display("FAIL %0t: push credit model ends at %0d", $time, pushCredits);
      errorCount++;
    end
    finishTest("random");

    assertFails = sharedMultiFifo_inst.sharedMultiFifoAsserts_inst.failCount;
    $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             testCount, testsFailed, errorCount, assertFails);
    if (errorCount == 0 && assertFails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : sharedMultiFifoTb

`default_nettype wire

//--- verification/sharedMultiFifo_asserts.sv
`timescale 1ns/1ps

`include "mfifo_defs.svh"

`default_nettype none

module sharedMultiFifoAsserts
  import mfifoPkg::*;
(
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        pushCredit,
  input  logic                        pushFull,
  input  logic [`MFIFO_NUM_FIFOS-1:0] popCredit,
  input  logic                        popValid,
  input  fifoIdT                      popFifoId,
  input  logic [`MFIFO_NUM_FIFOS-1:0] popEmpty
);

  // Pop credits the receiver has handed out and the DUT has not yet used
  int creditModel [`MFIFO_NUM_FIFOS];
  int pushCreditFails = 0;
  int popCreditFails = 0;
  int fullFails = 0;
  int resetFails = 0;
  int failCount;

  // Total read by the testbench at the end of the run
  assign failCount = pushCreditFails + popCreditFails + fullFails + resetFails;

  always_ff @(posedge clk) begin
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      if (!rstN) begin
        creditModel[i] <= `MFIFO_POP_CREDITS;
      end else begin
        creditModel[i] <= creditModel[i] + int'(popCredit[i]) -
                          int'(popValid && (popFifoId == fifoIdT'(i)));
      end
    end
  end

  // Every returned push credit frees the entry of the pop one cycle before
  pushCreditFromPop: assert property (@(posedge clk) disable iff (!rstN)
    pushCredit |-> $past(popValid))
    else begin
      $error("pushCredit pulse without a pop in the cycle before");
      pushCreditFails++;
    end

  // The popped FIFO must have held a credit
  popNeedsCredit: assert property (@(posedge clk) disable iff (!rstN)
    popValid |-> (creditModel[popFifoId] > 0))
    else begin
      $error("pop on a FIFO that holds no pop credit");
      popCreditFails++;
    end

  // All entries in use means some list still holds items
  fullNotEmpty: assert property (@(posedge clk) disable iff (!rstN)
    pushFull |-> !(&popEmpty))
    else begin
      $error("pushFull while every FIFO reports empty");
      fullFails++;
    end

  // First cycle out of reset shows idle outputs
  idleAfterReset: assert property (@(posedge clk)
    $rose(rstN) |-> (!popValid && !pushCredit && !pushFull && (&popEmpty)))
    else begin
      $error("outputs active in the first cycle after reset");
      resetFails++;
    end

endmodule : sharedMultiFifoAsserts

bind sharedMultiFifo sharedMultiFifoAsserts sharedMultiFifoAsserts_inst (
  .clk(clk),
  .rstN(rstN),
  .pushCredit(pushCredit),
  .pushFull(pushFull),
  .popCredit(popCredit),
  .popValid(popValid),
  .popFifoId(popFifoId),
  .popEmpty(popEmpty)
);

`default_nettype wire

//--- verilog/creditPopCtrl.sv
`timescale 1ns/1ps

`include "mfifo_defs.svh"

`default_nettype none

module creditPopCtrl
  import mfifoPkg::*;
(
  input  logic                             clk,
  input  logic                             rstN,

  // Heads offered by the pointer manager
  input  logic [`MFIFO_NUM_FIFOS-1:0]      headValid,
  input  addrT [`MFIFO_NUM_FIFOS-1:0]      headAddr,
  output logic [`MFIFO_NUM_FIFOS-1:0]      headReady,

  // Pop port towards the receiver
  input  logic [`MFIFO_NUM_FIFOS-1:0]      popCredit,
  output logic                             popValid,
  output fifoIdT                           popFifoId,
  output dataT                             popData,

  // Arbiter interface
  output logic [`MFIFO_NUM_FIFOS-1:0]      arbRequest,
  input  logic [`MFIFO_NUM_FIFOS-1:0]      arbGrant,
  output logic                             arbEnablePriorityUpdate,

  // Data RAM read port
  output addrT                             dataRamRdAddr,
  input  dataT                             dataRamRdData,

  // Entry released back to the freelist
  output logic                             deallocValid,
  output addrT                             deallocAddr
);

  localparam int CredW = $clog2(`MFIFO_POP_CREDITS + 1);

  logic [CredW-1:0] credit [`MFIFO_NUM_FIFOS];
  logic [`MFIFO_NUM_FIFOS-1:0] granted;
  logic grantAny;
  fifoIdT grantFifo;

  // Read slot that carries the granted head into the next cycle
  popStateT popState;
  fifoIdT rdFifo;
  addrT rdAddr;

  // A FIFO asks for the port only with a head and a credit
  // The FIFO in the read slot is held back, its next head is not known yet
  always_comb begin
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      arbRequest[i] = headValid[i] && (credit[i] != '0) &&
                      !((popState == popRead) && (rdFifo == fifoIdT'(i)));
    end
  end

  assign granted   = arbGrant & arbRequest;
  assign headReady = granted;
  assign grantAny  = |granted;

  // Priority only moves when the grant is really used
  assign arbEnablePriorityUpdate = grantAny;

  // Grant is one-hot, turn it into an index
  always_comb begin
    grantFifo = '0;
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      if (granted[i]) grantFifo = fifoIdT'(i);
    end
  end

  assign dataRamRdAddr = headAddr[grantFifo];

  // RAM data arrives one cycle after the grant together with the slot
  assign popValid     = (popState == popRead);
  assign popFifoId    = rdFifo;
  assign popData      = dataRamRdData;
  assign deallocValid = popValid;
  assign deallocAddr  = rdAddr;

  // Credit is taken at the grant, the pop itself always follows
  always_ff @(posedge clk) begin
    if (!rstN) begin
      popState <= popIdle;
      for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
        credit[i] <= CredW'(`MFIFO_POP_CREDITS);
      end
    end else begin
      popState <= grantAny ? popRead : popIdle;
      for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
        credit[i] <= credit[i] + CredW'(popCredit[i]) - CredW'(granted[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    rdFifo <= grantFifo;
    rdAddr <= dataRamRdAddr;
  end

endmodule : creditPopCtrl

`default_nettype wire

//--- verilog/freelistPushCtrl.sv
`timescale 1ns/1ps

`include "mfifo_defs.svh"

`default_nettype none

module freelistPushCtrl
  import mfifoPkg::*;
(
  input  logic   clk,
  input  logic   rstN,

  // Push port from the sender
  input  logic   pushValid,
  input  fifoIdT pushFifoId,
  input  dataT   pushData,
  output logic   pushCredit,
  output logic   pushFull,

  // Data RAM write port
  output logic   dataRamWrValid,
  output addrT   dataRamWrAddr,
  output dataT   dataRamWrData,

  // Newly allocated entry for the pointer manager
  output logic   tailValid,
  output fifoIdT tailFifoId,
  output addrT   tailAddr,

  // Entry released by the pop controller
  input  logic   deallocValid,
  input  addrT   deallocAddr
);

  // One bit per shared entry, set while the entry is free
  logic [`MFIFO_DEPTH-1:0] freeMap;
  addrT allocAddr;

  // Pick the lowest free entry
  // The loop runs downward so the last hit is the lowest index
  always_comb begin
    allocAddr = '0;
    for (int i = `MFIFO_DEPTH - 1; i >= 0; i--) begin
      if (freeMap[i]) begin
        allocAddr = addrT'(i);
      end
    end
  end

  // The sender holds one credit per free entry, so a push always finds a slot
  assign pushFull = ~|freeMap;

  // Payload goes straight into the data RAM at the push edge
  assign dataRamWrValid = pushValid;
  assign dataRamWrAddr  = allocAddr;
  assign dataRamWrData  = pushData;

  // The same entry is handed to the linked list of the target FIFO
  assign tailValid  = pushValid;
  assign tailFifoId = pushFifoId;
  assign tailAddr   = allocAddr;

  // A pushed entry is never free, so allocate and release never collide
  always_ff @(posedge clk) begin
    if (!rstN) begin
      freeMap    <= '1;
      pushCredit <= 1'b0;
    end else begin
      if (pushValid) begin
        freeMap[allocAddr] <= 1'b0;
      end
      if (deallocValid) begin
        freeMap[deallocAddr] <= 1'b1;
      end
      // Credit returns at the same edge the entry rejoins the free set
      pushCredit <= deallocValid;
    end
  end

endmodule : freelistPushCtrl

`default_nettype wire

//--- verilog/linkedListPtrMgr.sv
`timescale 1ns/1ps

`include "mfifo_defs.svh"

`default_nettype none

module linkedListPtrMgr
  import mfifoPkg::*;
(
  input  logic                             clk,
  input  logic                             rstN,

  // Entry allocated by the push controller
  input  logic                             tailValid,
  input  fifoIdT                           tailFifoId,
  input  addrT                             tailAddr,

  // Pointer RAM ports
  output logic                             ptrRamWrValid,
  output addrT                             ptrRamWrAddr,
  output addrT                             ptrRamWrData,
  output addrT                             ptrRamRdAddr,
  input  addrT                             ptrRamRdData,

  // Head of every list towards the pop controller
  output logic [`MFIFO_NUM_FIFOS-1:0]      headValid,
  output addrT [`MFIFO_NUM_FIFOS-1:0]      headAddr,
  input  logic [`MFIFO_NUM_FIFOS-1:0]      headReady,
  output logic [`MFIFO_NUM_FIFOS-1:0]      popEmpty
);

  localparam int CntW = $clog2(`MFIFO_DEPTH + 1);

  logic [CntW-1:0] count [`MFIFO_NUM_FIFOS];
  addrT tail [`MFIFO_NUM_FIFOS];
  logic [`MFIFO_NUM_FIFOS-1:0] pushHit;
  logic popTake;
  fifoIdT popFifo;
  logic needReload;

  // A link read is in flight and lands as the new head next edge
  logic reloadValid;
  fifoIdT reloadFifo;
  logic fwdValid;
  addrT fwdAddr;
  addrT nextHead;

  // Decode which list gains an entry and which list loses its head
  always_comb begin
    popTake = 1'b0;
    popFifo = '0;
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      pushHit[i] = tailValid && (tailFifoId == fifoIdT'(i));
      popEmpty[i] = (count[i] == '0);
      if (headReady[i]) begin
        popTake = 1'b1;
        popFifo = fifoIdT'(i);
      end
    end
  end

  // A list that keeps an item after the pop must fetch the next link
  // With one item and a push in the same cycle the link is being written right now
  assign needReload = popTake &&
                      ((count[popFifo] > CntW'(1)) ||
                       ((count[popFifo] == CntW'(1)) && pushHit[popFifo]));

  // Appending to a non-empty list links the old tail to the new entry
  assign ptrRamWrValid = tailValid && (count[tailFifoId] != '0);
  assign ptrRamWrAddr  = tail[tailFifoId];
  assign ptrRamWrData  = tailAddr;
  assign ptrRamRdAddr  = headAddr[popFifo];

  // The RAM returns old data on a same-address collision, so bypass it
  assign nextHead = fwdValid ? fwdAddr : ptrRamRdData;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      headValid   <= '0;
      reloadValid <= 1'b0;
      for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
        count[i] <= '0;
      end
    end else begin
      reloadValid <= needReload;
      for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
        count[i] <= count[i] + CntW'(pushHit[i]) - CntW'(headReady[i]);
        // Head stays invalid for one cycle while its successor is fetched
        if (headReady[i]) headValid[i] <= 1'b0;
        if (pushHit[i] && (count[i] == '0)) headValid[i] <= 1'b1;
        if (reloadValid && (reloadFifo == fifoIdT'(i))) headValid[i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    reloadFifo <= popFifo;
    fwdValid   <= ptrRamWrValid && (ptrRamWrAddr == ptrRamRdAddr);
    fwdAddr    <= ptrRamWrData;
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      if (pushHit[i]) tail[i] <= tailAddr;
      if (pushHit[i] && (count[i] == '0)) headAddr[i] <= tailAddr;
      if (reloadValid && (reloadFifo == fifoIdT'(i))) headAddr[i] <= nextHead;
    end
  end

endmodule : linkedListPtrMgr

`default_nettype wire

//--- verilog/mfifoPkg.sv
`include "mfifo_defs.svh"

`default_nettype none

package mfifoPkg;

  // Index of one logical FIFO
  typedef logic [$clog2(`MFIFO_NUM_FIFOS)-1:0] fifoIdT;

  // Address of one shared entry, used for both RAMs
  typedef logic [$clog2(`MFIFO_DEPTH)-1:0] addrT;

  // One payload word
  typedef logic [`MFIFO_WIDTH-1:0] dataT;

  // State of the single data RAM read slot on the pop side
  typedef enum logic {
    popIdle,
    popRead
  } popStateT;

endpackage : mfifoPkg

`default_nettype wire

//--- verilog/mfifo_defs.svh
`ifndef MFIFO_DEFS_SVH
`define MFIFO_DEFS_SVH

`default_nettype none

// Number of logical FIFOs sharing the storage
`define MFIFO_NUM_FIFOS 4

// Shared entries in the data RAM
// The push sender also starts with this many credits
`define MFIFO_DEPTH 16

// Payload width in bits
`define MFIFO_WIDTH 8

// Pop credits each logical FIFO holds out of reset
`define MFIFO_POP_CREDITS 2

`default_nettype wire

`endif

//--- verilog/roundRobinArbiter.sv
`timescale 1ns/1ps

`default_nettype none

module roundRobinArbiter #(
  parameter int NumRequests = 4
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [NumRequests-1:0] request,
  output logic [NumRequests-1:0] grant,
  input  logic                   enablePriorityUpdate
);

  localparam int IdxW = $clog2(NumRequests);

  // Index that has the highest priority this cycle
  logic [IdxW-1:0] prio;
  int grantIdx;

  // Scan from the priority index and wrap around, first requester wins
  always_comb begin
    int idx;
    grant    = '0;
    grantIdx = 0;
    for (int k = NumRequests - 1; k >= 0; k--) begin
      idx = (int'(prio) + k) % NumRequests;
      if (request[idx]) begin
        grant    = '0;
        grant[idx] = 1'b1;
        grantIdx = idx;
      end
    end
  end

  // The one just granted drops to lowest priority
  always_ff @(posedge clk) begin
    if (!rstN) begin
      prio <= '0;
    end else if (enablePriorityUpdate) begin
      prio <= IdxW'((grantIdx + 1) % NumRequests);
    end
  end

endmodule : roundRobinArbiter

`default_nettype wire

//--- verilog/sharedMultiFifo.sv
`timescale 1ns/1ps

`include "mfifo_defs.svh"

`default_nettype none

module sharedMultiFifo
  import mfifoPkg::*;
(
  input  logic                             clk,
  input  logic                             rstN,

  // Push side with valid/credit flow control
  input  logic                             pushValid,
  input  fifoIdT                           pushFifoId,
  input  dataT                             pushData,
  output logic                             pushCredit,
  output logic                             pushFull,

  // Pop side with one credit count per FIFO
  input  logic [`MFIFO_NUM_FIFOS-1:0]      popCredit,
  output logic                             popValid,
  output fifoIdT                           popFifoId,
  output dataT                             popData,
  output logic [`MFIFO_NUM_FIFOS-1:0]      popEmpty
);

  // Push controller to pointer manager
  logic tailValid;
  fifoIdT tailFifoId;
  addrT tailAddr;

  // Pointer manager and pop controller
  logic [`MFIFO_NUM_FIFOS-1:0] headValid;
  addrT [`MFIFO_NUM_FIFOS-1:0] headAddr;
  logic [`MFIFO_NUM_FIFOS-1:0] headReady;

  // Arbiter handshake
  logic [`MFIFO_NUM_FIFOS-1:0] arbRequest;
  logic [`MFIFO_NUM_FIFOS-1:0] arbGrant;
  logic arbEnablePriorityUpdate;

  // Entry release back to the freelist
  logic deallocValid;
  addrT deallocAddr;

  // RAM ports
  logic dataRamWrValid;
  addrT dataRamWrAddr;
  dataT dataRamWrData;
  addrT dataRamRdAddr;
  dataT dataRamRdData;
  logic ptrRamWrValid;
  addrT ptrRamWrAddr;
  addrT ptrRamWrData;
  addrT ptrRamRdAddr;
  addrT ptrRamRdData;

  freelistPushCtrl freelistPushCtrl_inst (
    .clk, .rstN, .pushValid, .pushFifoId, .pushData, .pushCredit, .pushFull,
    .dataRamWrValid, .dataRamWrAddr, .dataRamWrData,
    .tailValid, .tailFifoId, .tailAddr, .deallocValid, .deallocAddr
  );

  linkedListPtrMgr linkedListPtrMgr_inst (
    .clk, .rstN, .tailValid, .tailFifoId, .tailAddr,
    .ptrRamWrValid, .ptrRamWrAddr, .ptrRamWrData, .ptrRamRdAddr, .ptrRamRdData,
    .headValid, .headAddr, .headReady, .popEmpty
  );

  creditPopCtrl creditPopCtrl_inst (
    .clk, .rstN, .headValid, .headAddr, .headReady,
    .popCredit, .popValid, .popFifoId, .popData,
    .arbRequest, .arbGrant, .arbEnablePriorityUpdate,
    .dataRamRdAddr, .dataRamRdData, .deallocValid, .deallocAddr
  );

  // Payload storage
  syncReadRam #(.DataWidth(`MFIFO_WIDTH)) dataRam_inst (
    .clk, .wrValid(dataRamWrValid), .wrAddr(dataRamWrAddr), .wrData(dataRamWrData),
    .rdAddr(dataRamRdAddr), .rdData(dataRamRdData)
  );

  // Next-entry links of all lists
  syncReadRam #(.DataWidth($bits(addrT))) ptrRam_inst (
    .clk, .wrValid(ptrRamWrValid), .wrAddr(ptrRamWrAddr), .wrData(ptrRamWrData),
    .rdAddr(ptrRamRdAddr), .rdData(ptrRamRdData)
  );

  roundRobinArbiter #(.NumRequests(`MFIFO_NUM_FIFOS)) roundRobinArbiter_inst (
    .clk, .rstN, .request(arbRequest), .grant(arbGrant),
    .enablePriorityUpdate(arbEnablePriorityUpdate)
  );

endmodule : sharedMultiFifo

`default_nettype wire

//--- verilog/syncReadRam.sv
`timescale 1ns/1ps

`include "mfifo_defs.svh"

`default_nettype none

module syncReadRam #(
  parameter int DataWidth = 8
) (
  input  logic                               clk,
  input  logic                               wrValid,
  input  logic [$clog2(`MFIFO_DEPTH)-1:0]    wrAddr,
  input  logic [DataWidth-1:0]               wrData,
  input  logic [$clog2(`MFIFO_DEPTH)-1:0]    rdAddr,
  output logic [DataWidth-1:0]               rdData
);

  logic [DataWidth-1:0] mem [`MFIFO_DEPTH];

  // Read data is registered, so it shows up one cycle after the address
  // A read of the address being written returns the old word
  always_ff @(posedge clk) begin
    if (wrValid) begin
      mem[wrAddr] <= wrData;
    end
    rdData <= mem[rdAddr];
  end

endmodule : syncReadRam

`default_nettype wire
